//--- wave_meas_pkg.sv
// ----------------------------------------------------------
// widths, channel count and meter FSM states for the meter
// tick counts wrap at 2**time_w, so differences stay modular
// chan_w must be wide enough to index chan_num channels
// ----------------------------------------------------------
package wave_meas_pkg;

    // sizes
    localparam int chan_num = 2;        // wave channels
    localparam int time_w   = 32;       // tick count width
    localparam int cnt_w    = 16;       // edge count width
    localparam int chan_w   = 1;        // channel index width

    // a number of pll_clk ticks, wraps modulo 2**time_w
    typedef logic [time_w-1:0] tick_t;

    // a number of wave periods in one window
    typedef logic [cnt_w-1:0] edge_cnt_t;

    // channel index carried with each result
    typedef logic [chan_w-1:0] chan_t;

    // channel meter sequencer
    typedef enum logic [1:0] {
        idle    = 2'd0,     // after reset or after result taken
        armed   = 2'd1,     // n valid, waiting for start edge
        measure = 2'd2,     // window open, counting edges
        hold    = 2'd3      // result stable until taken
    } meter_state_t;

endpackage

//--- wave_edge_sync.sv
// ----------------------------------------------------------
// two-flop synchronizer plus rising edge flag, per channel
// wave_sync lags wave_in by two pll_clk cycles
// no glitch filtering, a short pulse may be missed or passed
// ----------------------------------------------------------
`timescale 1ns/1ps

module wave_edge_sync (
    input  logic                               pll_clk,
    input  logic                               sys_rst_n,
    input  logic [wave_meas_pkg::chan_num-1:0] wave_in,     // async square waves
    output logic [wave_meas_pkg::chan_num-1:0] wave_sync,   // synchronized level
    output logic [wave_meas_pkg::chan_num-1:0] rise_pulse   // one cycle per rising edge
);

    logic [wave_meas_pkg::chan_num-1:0] meta_q;     // first stage, may be metastable
    logic [wave_meas_pkg::chan_num-1:0] sync_q;     // second stage, safe to use
    logic [wave_meas_pkg::chan_num-1:0] dly_q;      // previous sync level

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
            dly_q  <= '0;
        end else begin
            meta_q <= wave_in;
            sync_q <= meta_q;
            dly_q  <= sync_q;   // edge reference
        end
    end

    assign wave_sync  = sync_q;
    assign rise_pulse = sync_q & ~dly_q;    // high in first high cycle

endmodule

//--- wave_period_meter.sv
// ----------------------------------------------------------
// one channel: window of n periods from a start rising edge
// period is n*P ticks, high_time is n*H ticks
// n is sampled at the start edge; n == 0 keeps the meter idle
// result holds while done is high, waves meanwhile are skipped
// ----------------------------------------------------------
`timescale 1ns/1ps

module wave_period_meter (
    input  logic                      pll_clk,
    input  logic                      sys_rst_n,
    input  logic                      wave_sync,    // synchronized wave level
    input  logic                      rise_pulse,   // synchronized rising edge
    input  wave_meas_pkg::edge_cnt_t  n,            // periods per window
    input  logic                      taken,        // arbiter took the result
    output logic                      done,         // result waiting
    output wave_meas_pkg::tick_t      period,       // n periods in ticks
    output wave_meas_pkg::tick_t      high_time     // high ticks over n periods
);

    wave_meas_pkg::meter_state_t state;
    logic                        closing;       // extra cycle after the last edge
    wave_meas_pkg::tick_t        time_base;     // free running stamp source
    wave_meas_pkg::tick_t        start_stamp;
    wave_meas_pkg::tick_t        period_q;
    wave_meas_pkg::tick_t        high_q;
    wave_meas_pkg::edge_cnt_t    n_lat;         // n for the open window
    wave_meas_pkg::edge_cnt_t    edge_cnt;      // edges seen in window
    logic                        start_win;
    logic                        last_edge;
    logic                        count_en;

    assign start_win = (state == wave_meas_pkg::idle || state == wave_meas_pkg::armed) &&
                       rise_pulse && (n != '0);
    assign count_en  = (state == wave_meas_pkg::measure) && !closing;
    assign last_edge = count_en && rise_pulse &&
                       (edge_cnt == wave_meas_pkg::edge_cnt_t'(n_lat - 1'b1));

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) time_base <= '0;
        else            time_base <= time_base + 1'b1;  // wraps, diff stays valid
    end

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= wave_meas_pkg::idle;
            closing  <= 1'b0;
            edge_cnt <= '0;
            n_lat    <= '0;
        end else begin
            case (state)
                wave_meas_pkg::idle: begin
                    if (start_win)     state <= wave_meas_pkg::measure;
                    else if (n != '0)  state <= wave_meas_pkg::armed;
                end
                wave_meas_pkg::armed: begin
                    if (start_win)     state <= wave_meas_pkg::measure;
                    else if (n == '0)  state <= wave_meas_pkg::idle;   // n withdrawn
                end
                wave_meas_pkg::measure: begin
                    if (closing) begin
                        state   <= wave_meas_pkg::hold;
                        closing <= 1'b0;
                    end else if (last_edge) begin
                        closing <= 1'b1;    // period already latched
                    end
                end
                wave_meas_pkg::hold: begin
                    if (taken) state <= wave_meas_pkg::idle;
                end
                default: state <= wave_meas_pkg::idle;
            endcase
            if (start_win) begin
                edge_cnt <= '0;
                n_lat    <= n;      // n fixed for the window
            end else if (count_en && rise_pulse) begin
                edge_cnt <= edge_cnt + 1'b1;
            end
        end
    end

    // result registers, only meaningful while done
    always_ff @(posedge pll_clk) begin
        if (start_win) begin
            start_stamp <= time_base;
            high_q      <= '0;
        end else if (count_en && wave_sync) begin
            high_q <= high_q + 1'b1;    // includes the closing edge cycle
        end
        if (last_edge) period_q <= time_base - start_stamp;  // modular diff
    end

    assign done      = (state == wave_meas_pkg::hold);
    assign period    = period_q;
    assign high_time = high_q;

endmodule

//--- wave_result_arbiter.sv
// ----------------------------------------------------------
// round robin between the two meters, four-phase req/ack out
// a new req only starts with req and ack both low
// output data holds from req rise until req falls
// ----------------------------------------------------------
`timescale 1ns/1ps

module wave_result_arbiter (
    input  logic                               pll_clk,
    input  logic                               sys_rst_n,
    input  logic [wave_meas_pkg::chan_num-1:0] done,        // meter results waiting
    input  wave_meas_pkg::tick_t               period_0,
    input  wave_meas_pkg::tick_t               high_0,
    input  wave_meas_pkg::tick_t               period_1,
    input  wave_meas_pkg::tick_t               high_1,
    output logic [wave_meas_pkg::chan_num-1:0] taken,       // one cycle grant to meter
    output logic                               res_req,
    input  logic                               res_ack,
    output wave_meas_pkg::chan_t               res_chan,
    output wave_meas_pkg::tick_t               res_period,
    output wave_meas_pkg::tick_t               res_high
);

    wave_meas_pkg::chan_t last_chan;    // last channel served
    wave_meas_pkg::chan_t next_chan;    // first in line this round
    wave_meas_pkg::chan_t sel_chan;
    wave_meas_pkg::tick_t sel_period;
    wave_meas_pkg::tick_t sel_high;
    logic                 grant;

    assign next_chan = wave_meas_pkg::chan_t'(last_chan + 1'b1);
    assign sel_chan  = done[next_chan] ? next_chan : last_chan;   // else the other one
    assign grant     = !res_req && !res_ack && (done != '0);      // port fully idle

    always_comb begin
        taken = '0;
        if (grant) taken[sel_chan] = 1'b1;
    end

    always_comb begin
        if (sel_chan == wave_meas_pkg::chan_t'(0)) begin
            sel_period = period_0;
            sel_high   = high_0;
        end else begin
            sel_period = period_1;
            sel_high   = high_1;
        end
    end

    // handshake and pointer
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            res_req   <= 1'b0;
            last_chan <= wave_meas_pkg::chan_t'(wave_meas_pkg::chan_num - 1);  // ch0 first
        end else if (grant) begin
            res_req   <= 1'b1;
            last_chan <= sel_chan;
        end else if (res_req && res_ack) begin
            res_req <= 1'b0;    // ack seen, wait for it to drop
        end
    end

    // output data, loaded only on grant so it holds under req
    always_ff @(posedge pll_clk) begin
        if (grant) begin
            res_chan   <= sel_chan;
            res_period <= sel_period;
            res_high   <= sel_high;
        end
    end

endmodule

//--- square_wave_freq.sv
// ----------------------------------------------------------
// two channel square wave meter on pll_clk
// results are n*period and n*high ticks, consumer divides
// res_* follow a four-phase req/ack handshake
// ----------------------------------------------------------
`timescale 1ns/1ps

module square_wave_freq (
    input  logic                               pll_clk,
    input  logic                               sys_rst_n,
    input  logic [wave_meas_pkg::chan_num-1:0] wave_in,     // async waves
    input  wave_meas_pkg::edge_cnt_t           n,           // quasi static
    output logic                               res_req,
    input  logic                               res_ack,
    output wave_meas_pkg::chan_t               res_chan,
    output wave_meas_pkg::tick_t               res_period,
    output wave_meas_pkg::tick_t               res_high
);

    logic [wave_meas_pkg::chan_num-1:0] wave_sync;
    logic [wave_meas_pkg::chan_num-1:0] rise_pulse;
    logic [wave_meas_pkg::chan_num-1:0] done;
    logic [wave_meas_pkg::chan_num-1:0] taken;
    wave_meas_pkg::tick_t               period_0;
    wave_meas_pkg::tick_t               high_0;
    wave_meas_pkg::tick_t               period_1;
    wave_meas_pkg::tick_t               high_1;

    wave_edge_sync edge_sync_i (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .wave_in    (wave_in),
        .wave_sync  (wave_sync),
        .rise_pulse (rise_pulse)
    );

    wave_period_meter meter_0 (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .wave_sync  (wave_sync[0]),
        .rise_pulse (rise_pulse[0]),
        .n          (n),
        .taken      (taken[0]),
        .done       (done[0]),
        .period     (period_0),
        .high_time  (high_0)
    );

    wave_period_meter meter_1 (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .wave_sync  (wave_sync[1]),
        .rise_pulse (rise_pulse[1]),
        .n          (n),
        .taken      (taken[1]),
        .done       (done[1]),
        .period     (period_1),
        .high_time  (high_1)
    );

    wave_result_arbiter arbiter_i (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .done       (done),
        .period_0   (period_0),
        .high_0     (high_0),
        .period_1   (period_1),
        .high_1     (high_1),
        .taken      (taken),
        .res_req    (res_req),
        .res_ack    (res_ack),
        .res_chan   (res_chan),
        .res_period (res_period),
        .res_high   (res_high)
    );

endmodule

//--- square_wave_freq_asserts.sv
// ----------------------------------------------------------
// four-phase checks on the result port, bound into the top
// all checks are off while sys_rst_n is low
// ----------------------------------------------------------
`timescale 1ns/1ps

module square_wave_freq_asserts (
    input logic                               pll_clk,
    input logic                               sys_rst_n,
    input logic                               res_req,
    input logic                               res_ack,
    input wave_meas_pkg::chan_t               res_chan,
    input wave_meas_pkg::tick_t               res_period,
    input wave_meas_pkg::tick_t               res_high,
    input logic [wave_meas_pkg::chan_num-1:0] taken     // arbiter grant to meters
);

    // req stays up until the consumer answers
    req_held: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        res_req && !res_ack |=> res_req)
        else $error("res_req dropped before res_ack");

    data_stable: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        res_req && !res_ack |=> $stable(res_chan) && $stable(res_period) && $stable(res_high))
        else $error("result data changed while res_req was waiting for res_ack");

    // ack still high, no new request yet
    no_rise_under_ack: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        !res_req && res_ack |=> !res_req)
        else $error("res_req rose while res_ack was high");

    no_taken_busy: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        taken != '0 |-> !res_req)
        else $error("taken pulsed while res_req was high");

endmodule

bind square_wave_freq square_wave_freq_asserts asserts_i (
    .pll_clk    (pll_clk),
    .sys_rst_n  (sys_rst_n),
    .res_req    (res_req),
    .res_ack    (res_ack),
    .res_chan   (res_chan),
    .res_period (res_period),
    .res_high   (res_high),
    .taken      (taken)
);

//--- tb_square_wave_freq.sv
// ----------------------------------------------------------
// directed testbench for the two channel square wave meter
// waves are built from whole pll_clk ticks, results are exact
// the DUT is reset before every test, stops at first mismatch
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_square_wave_freq;

    localparam int rst_cycles  = 16;
    // test 1 idle, then windows of tests 2 to 5, back-pressure, n == 0 wait
    localparam int test_cycles = 50 + 2 * (4 + 1) * 10 + 2 * (3 + 1) * 12
                                 + 200 + 3 * (3 + 1) * 12 + 100 + (6 + 1) * 10
                                 + 5 * (rst_cycles + 8);
    localparam int timeout_cycles = 3 * test_cycles;    // ack delays, skipped waves

    logic                               pll_clk;
    logic                               sys_rst_n;
    logic [wave_meas_pkg::chan_num-1:0] wave_in;
    wave_meas_pkg::edge_cnt_t           n;
    logic                               res_req;
    logic                               res_ack;
    wave_meas_pkg::chan_t               res_chan;
    wave_meas_pkg::tick_t               res_period;
    wave_meas_pkg::tick_t               res_high;

    logic                 wave_en    [wave_meas_pkg::chan_num];
    int                   wave_hi    [wave_meas_pkg::chan_num];    // high ticks per period
    int                   wave_lo    [wave_meas_pkg::chan_num];    // low ticks per period
    wave_meas_pkg::tick_t exp_period [wave_meas_pkg::chan_num];
    wave_meas_pkg::tick_t exp_high   [wave_meas_pkg::chan_num];
    int                   got        [wave_meas_pkg::chan_num];    // results seen per channel
    int                   ack_hold;     // extra ack delay, read at req rise

    square_wave_freq square_wave_freq_i (
        .pll_clk    (pll_clk),
        .sys_rst_n  (sys_rst_n),
        .wave_in    (wave_in),
        .n          (n),
        .res_req    (res_req),
        .res_ack    (res_ack),
        .res_chan   (res_chan),
        .res_period (res_period),
        .res_high   (res_high)
    );

    initial begin
        pll_clk = 1'b0;
        forever #4 pll_clk = ~pll_clk;     // 8 ns period
    end

    // both wave channels, one phase counter each
    initial begin : wave_gen
        int                                 phase [wave_meas_pkg::chan_num];
        logic [wave_meas_pkg::chan_num-1:0] level;
        wave_in = '0;
        level   = '0;
        for (int c = 0; c < wave_meas_pkg::chan_num; c++) phase[c] = 0;
        forever begin
            @(posedge pll_clk);
            for (int c = 0; c < wave_meas_pkg::chan_num; c++) begin
                if (!wave_en[c] || !sys_rst_n) begin
                    level[c] = 1'b0;   // parked low, restarts on a true edge
                    phase[c] = 0;
                end else begin
                    level[c] = (phase[c] < wave_hi[c]);
                    phase[c] = (phase[c] + 1 >= wave_hi[c] + wave_lo[c]) ? 0 : phase[c] + 1;
                end
            end
            wave_in <= level;
        end
    end

    // four-phase consumer, random ack delay
    initial begin : ack_responder
        int delay;
        void'($urandom(32'hc7a6_17e3));    // fixed seed
        res_ack = 1'b0;
        forever begin
            @(posedge pll_clk);
            if (res_req === 1'b1 && res_ack === 1'b0) begin
                delay = ack_hold + int'($urandom % 4);
                repeat (delay) @(posedge pll_clk);
                res_ack <= 1'b1;
                do @(posedge pll_clk); while (res_req === 1'b1);
                res_ack <= 1'b0;    // req gone, release
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge pll_clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted by the cycle limit");
    end

    task automatic check_value(input string name, input wave_meas_pkg::tick_t actual,
                               input wave_meas_pkg::tick_t expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // p == 0 parks the channel, expected values are n*P and n*H
    task automatic configure_wave(input int c, input int p, input int h, input int nwin);
        wave_en[c]    = (p > 0);
        wave_hi[c]    = h;
        wave_lo[c]    = p - h;
        exp_period[c] = wave_meas_pkg::tick_t'(nwin * p);
        exp_high[c]   = wave_meas_pkg::tick_t'(nwin * h);
        got[c]        = 0;
    endtask

    task automatic apply_reset(input wave_meas_pkg::edge_cnt_t n_val);
        @(posedge pll_clk);
        while (res_req === 1'b1 || res_ack === 1'b1) @(posedge pll_clk);   // port idle
        n         <= n_val;
        sys_rst_n <= 1'b0;
        repeat (rst_cycles) @(posedge pll_clk);
        sys_rst_n <= 1'b1;
    endtask

    task automatic receive_result(output wave_meas_pkg::chan_t chan);
        wave_meas_pkg::tick_t per;
        wave_meas_pkg::tick_t hi;
        do @(posedge pll_clk); while (res_req !== 1'b1);
        chan = res_chan;
        per  = res_period;
        hi   = res_high;
        check_value("res_period", per, exp_period[chan]);
        check_value("res_high", hi, exp_high[chan]);
        while (res_ack !== 1'b1) begin     // data frozen until ack
            @(posedge pll_clk);
            check_value("res_chan", wave_meas_pkg::tick_t'(res_chan),
                        wave_meas_pkg::tick_t'(chan));
            check_value("res_period", res_period, per);
            check_value("res_high", res_high, hi);
        end
        while (res_req === 1'b1) @(posedge pll_clk);
        got[chan]++;
    endtask

    task automatic test_reset_state();
        configure_wave(0, 0, 0, 0);
        configure_wave(1, 0, 0, 0);
        apply_reset(16'd4);
        repeat (50) begin
            @(posedge pll_clk);
            check_value("res_req", wave_meas_pkg::tick_t'(res_req), '0);
        end
    endtask

    task automatic test_single_channel();
        wave_meas_pkg::chan_t chan;
        configure_wave(0, 10, 3, 4);    // 40 / 12
        configure_wave(1, 0, 0, 0);
        apply_reset(16'd4);
        repeat (2) begin
            receive_result(chan);
            check_value("res_chan", wave_meas_pkg::tick_t'(chan), '0);
        end
    endtask

    task automatic test_both_channels();
        wave_meas_pkg::chan_t chan;
        configure_wave(0, 12, 6, 3);
        configure_wave(1, 7, 2, 3);
        apply_reset(16'd3);
        while (got[0] < 2 || got[1] < 2) receive_result(chan);
    endtask

    task automatic test_back_pressure();
        wave_meas_pkg::chan_t chan;
        configure_wave(0, 12, 6, 3);
        configure_wave(1, 7, 2, 3);
        apply_reset(16'd3);
        ack_hold = 200;     // first result waits, both meters end up in hold
        receive_result(chan);
        ack_hold = 0;
        while (got[0] < 3 || got[1] < 3) receive_result(chan);
    endtask

    task automatic test_change_n();
        wave_meas_pkg::chan_t chan;
        configure_wave(0, 10, 4, 6);
        configure_wave(1, 8, 5, 6);
        apply_reset(16'd0);
        repeat (100) begin      // meters stay idle with n == 0
            @(posedge pll_clk);
            check_value("res_req", wave_meas_pkg::tick_t'(res_req), '0);
        end
        n <= 16'd6;
        while (got[0] < 1 || got[1] < 1) receive_result(chan);
    endtask

    initial begin : main
        sys_rst_n = 1'b0;
        n         = '0;
        ack_hold  = 0;
        for (int c = 0; c < wave_meas_pkg::chan_num; c++) configure_wave(c, 0, 0, 0);
        test_reset_state();
        test_single_channel();
        test_both_channels();
        test_back_pressure();
        test_change_n();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- src.f
wave_meas_pkg.sv
wave_edge_sync.sv
wave_period_meter.sv
wave_result_arbiter.sv
square_wave_freq.sv
square_wave_freq_asserts.sv
tb_square_wave_freq.sv

//--- Makefile
# Verilator flow for the two channel square wave meter

VERILATOR  ?= verilator
TOP        := tb_square_wave_freq
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation finished: FAIL
PASS_MSG   := Simulation finished: PASS
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "sim: failure reported, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "sim: run ended without a result line, see $(LOG)"; \
		exit 1; \
	fi
	@echo "sim: passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
